// ==== hdl/video_pkg.sv ====
// Video side type definitions
// Pixel quad, frame dimension, sync bundle
// Converter FSM state encoding
`default_nettype none

package video_pkg;

  ////////////////////////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////////////////////////

  // Pixels per line or lines per frame
  typedef logic [10:0] dim_t;

  // Four 8-bit pixels of a 2x2 quad
  // Byte 0 is pixel 00, then 01, 10, 11
  typedef logic [31:0] pixel_quad_t;

  ////////////////////////////////////////////////////////////
  // Sync bundle and FSM
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic de;     // Active pixel
    logic valid;
    logic hsync;
    logic vsync;
  } sync_t;

  typedef enum logic [2:0] {
    idle,
    wait_stream,   // Armed, waiting for vsync and data
    start_stream,  // Re-arm between frames
    start_frame,   // Waiting for first active line
    in_line
  } conv_state_t;

endpackage

`default_nettype wire

// ==== hdl/stream_pkg.sv ====
// Stream side type definitions
// Beat struct and status counter width
`default_nettype none

package stream_pkg;

  // One stream beat as delivered by the DMA engine
  typedef struct packed {
    logic                   tvalid;
    video_pkg::pixel_quad_t tdata;
    logic [3:0]             tkeep;  // Byte enables, all ones for a full quad
    logic [3:0]             tdest;  // Routing tag, not decoded
    logic                   tlast;  // Last beat of a frame
  } stream_beat_t;

  // Status counters, wrap at 64
  typedef logic [5:0] count_t;

endpackage

`default_nettype wire

// ==== hdl/video_ctrl_regs.sv ====
// Control and status registers
// Frame size, stream enable, frame and drop counters
`timescale 1ns/100ps
`default_nettype none

module video_ctrl_regs (
  input  wire logic        out_clk,
  input  wire logic        rstn,
  input  wire logic        reg_wr,
  input  wire logic [1:0]  reg_addr,
  input  wire logic [15:0] reg_wdata,
  input  wire logic        frame_pulse,
  input  wire logic        drop_pulse,
  output logic [15:0]      reg_rdata,
  output video_pkg::dim_t  x_size,
  output video_pkg::dim_t  y_size,
  output logic             stream_en
);
  import stream_pkg::*;

  count_t frame_cnt;
  count_t drop_cnt;

  always_ff @(posedge out_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      x_size    <= '0;
      y_size    <= '0;
      stream_en <= 1'b0;
      frame_cnt <= '0;
      drop_cnt  <= '0;
    end
    else
    begin
      if (reg_wr)
      begin
        case (reg_addr)
          2'd0:    x_size    <= reg_wdata[10:0];
          2'd1:    y_size    <= reg_wdata[10:0];
          2'd2:    stream_en <= reg_wdata[0];
          default: ;                            // Status is read only
        endcase
      end
      if (frame_pulse)
        frame_cnt <= frame_cnt + 1'b1;          // Wraps
      if (drop_pulse)
        drop_cnt <= drop_cnt + 1'b1;
    end
  end

  always_comb
  begin
    case (reg_addr)
      2'd0:    reg_rdata = {5'd0, x_size};
      2'd1:    reg_rdata = {5'd0, y_size};
      2'd2:    reg_rdata = {15'd0, stream_en};
      default: reg_rdata = {2'd0, drop_cnt, 2'd0, frame_cnt};
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/video_timing_gen.sv ====
// Raster timing generator
// Column and line counters with blanking
// Registered de, valid, hsync and vsync
`timescale 1ns/100ps
`default_nettype none

module video_timing_gen #(
  parameter int h_blank  = 280,
  parameter int hs_width = 44,
  parameter int v_blank  = 45
) (
  input  wire logic            out_clk,
  input  wire logic            rstn,
  input  wire video_pkg::dim_t x_size,
  input  wire video_pkg::dim_t y_size,
  output video_pkg::sync_t     raster
);
  import video_pkg::*;

  // One bit wider than dim_t to hold the blanked totals
  logic [11:0] col;
  logic [11:0] row;
  logic [11:0] h_total;
  logic [11:0] v_total;
  logic [11:0] hs_end;
  logic        line_end;
  logic        frame_end;
  logic        active;

  dim_t x_lat;  // Frame size held for the whole frame
  dim_t y_lat;

  assign h_total   = {1'b0, x_lat} + 12'(h_blank);
  assign v_total   = {1'b0, y_lat} + 12'(v_blank);
  assign hs_end    = {1'b0, x_lat} + 12'(hs_width);
  assign line_end  = (col == h_total - 1'b1);
  assign frame_end = line_end && (row == v_total - 1'b1);
  assign active    = (col < {1'b0, x_lat}) && (row < {1'b0, y_lat});

  ////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge out_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      col   <= '0;
      row   <= '0;
      x_lat <= '0;
      y_lat <= '0;
    end
    else
    begin
      col <= line_end ? 12'd0 : col + 1'b1;
      if (frame_end)
      begin
        row   <= '0;
        x_lat <= x_size;  // New size from next frame on
        y_lat <= y_size;
      end
      else if (line_end)
        row <= row + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Sync levels
  ////////////////////////////////////////////////////////////

  always_ff @(posedge out_clk or negedge rstn)
  begin
    if (!rstn)
      raster <= '0;
    else
    begin
      raster.de    <= active;
      raster.valid <= active;
      raster.hsync <= (col >= {1'b0, x_lat}) && (col < hs_end);
      raster.vsync <= (row == {1'b0, y_lat});  // First blank line
    end
  end

endmodule

`default_nettype wire

// ==== hdl/line_fifo.sv ====
// Single clock FIFO with synchronous clear
// First word fall through, zero data when empty
`timescale 1ns/100ps
`default_nettype none

module line_fifo #(
  parameter int data_width = 32,
  parameter int addr_width = 10
) (
  input  wire logic                  out_clk,
  input  wire logic                  rstn,
  input  wire logic                  clear,
  input  wire logic                  we,
  input  wire logic                  re,
  input  wire logic [data_width-1:0] wdata,
  output logic [data_width-1:0]      rdata,
  output logic                       empty,
  output logic                       full
);

  localparam int depth = 1 << addr_width;

  logic [data_width-1:0] mem [depth];
  logic [addr_width-1:0] wr_ptr;
  logic [addr_width-1:0] rd_ptr;
  logic [addr_width:0]   fill;
  logic                  do_wr;
  logic                  do_rd;

  assign do_wr = we && !full;   // Write on full is lost
  assign do_rd = re && !empty;
  assign empty = (fill == '0);
  assign full  = (fill == (addr_width + 1)'(depth));
  assign rdata = empty ? '0 : mem[rd_ptr];

  always_ff @(posedge out_clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge out_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end
    else if (clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/stream_to_video.sv ====
// Stream to video converter
// Frame FSM, beat intake against raster de count
// Line buffer, one line sync delay, output register
`timescale 1ns/100ps
`default_nettype none

module stream_to_video #(
  parameter int line_addr_width = 10,
  parameter int sync_addr_width = 12
) (
  input  wire logic                     out_clk,
  input  wire logic                     rstn,
  input  wire logic                     stream_en,
  input  wire video_pkg::sync_t         raster,
  input  wire stream_pkg::stream_beat_t in_beat,
  output logic                          tready,
  output video_pkg::sync_t              out_sync,
  output video_pkg::pixel_quad_t        out_pixels,
  output logic                          frame_pulse,
  output logic                          drop_pulse
);
  import video_pkg::*;

  conv_state_t state;
  sync_t       raster_q;
  sync_t       sync_rdata;
  sync_t       sync_dly;
  pixel_quad_t pix_rdata;
  logic [1:0]  en_sync;
  logic [1:0]  lines_seen;     // Raster line starts, saturates at 2
  logic [21:0] de_cnt;         // Raster de cycles in this frame
  logic [21:0] taken_cnt;      // Beats accepted in this frame
  logic [21:0] de_next;
  logic [21:0] taken_next;
  logic        vs_rise;
  logic        vs_fall;
  logic        de_rise;
  logic        take;
  logic        keep_all;
  logic        buf_clear;
  logic        sync_we;
  logic        sync_re;

  assign vs_rise  = raster.vsync & ~raster_q.vsync;
  assign vs_fall  = ~raster.vsync & raster_q.vsync;
  assign de_rise  = raster.de & ~raster_q.de;
  assign take     = tready & in_beat.tvalid;
  assign keep_all = (in_beat.tkeep == 4'hf);

  assign de_next    = de_cnt + (raster.de & raster.valid);
  assign taken_next = taken_cnt + take;
  assign buf_clear  = (state == idle) || (state == wait_stream) || (state == start_stream);

  always_ff @(posedge out_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      raster_q   <= '0;
      en_sync    <= '0;
      lines_seen <= '0;
    end
    else
    begin
      raster_q <= raster;
      en_sync  <= {en_sync[0], stream_en};
      if (de_rise && (lines_seen != 2'd2))
        lines_seen <= lines_seen + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Frame FSM and beat intake
  ////////////////////////////////////////////////////////////

  always_ff @(posedge out_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state     <= idle;
      tready    <= 1'b0;
      de_cnt    <= '0;
      taken_cnt <= '0;
    end
    else
    begin
      case (state)
        idle:
        begin
          tready <= 1'b0;
          state  <= wait_stream;
        end
        wait_stream:
        begin
          tready <= 1'b0;
          if (vs_rise && in_beat.tvalid && en_sync[1])
          begin
            state     <= start_frame;
            de_cnt    <= '0;
            taken_cnt <= '0;
          end
        end
        start_stream:   // Back to back frames, no new vsync wait
        begin
          tready    <= 1'b0;
          state     <= start_frame;
          de_cnt    <= '0;
          taken_cnt <= '0;
        end
        start_frame:
        begin
          if (de_rise)
          begin
            state  <= in_line;
            de_cnt <= 22'd1;   // Counts this first de cycle
            tready <= 1'b1;
          end
        end
        in_line:
        begin
          de_cnt    <= de_next;
          taken_cnt <= taken_next;
          if (vs_fall)
          begin
            tready <= 1'b0;
            state  <= en_sync[1] ? start_stream : wait_stream;
          end
          else
            tready <= (taken_next < de_next);  // Low once beats catch up
        end
        default: state <= idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Line buffer and sync delay
  ////////////////////////////////////////////////////////////

  // Write from first line start, read from second, so one line deep
  assign sync_we  = de_rise | (lines_seen != 2'd0);
  assign sync_re  = (de_rise & (lines_seen == 2'd1)) | (lines_seen == 2'd2);
  assign sync_dly = sync_re ? sync_rdata : '0;

  line_fifo #(
    .data_width (4),
    .addr_width (sync_addr_width)
  ) u_sync_delay (
    .out_clk (out_clk),
    .rstn    (rstn),
    .clear   (1'b0),
    .we      (sync_we),
    .re      (sync_re),
    .wdata   (raster),
    .rdata   (sync_rdata),
    .empty   (),
    .full    ()
  );

  line_fifo #(
    .data_width (32),
    .addr_width (line_addr_width)
  ) u_line_buf (
    .out_clk (out_clk),
    .rstn    (rstn),
    .clear   (buf_clear),
    .we      (take & keep_all),   // Partial quads dropped
    .re      (sync_dly.de),
    .wdata   (in_beat.tdata),
    .rdata   (pix_rdata),
    .empty   (),
    .full    ()
  );

  always_ff @(posedge out_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      out_sync    <= '0;
      out_pixels  <= '0;
      frame_pulse <= 1'b0;
      drop_pulse  <= 1'b0;
    end
    else
    begin
      out_sync    <= sync_dly;
      out_pixels  <= sync_dly.de ? pix_rdata : '0;
      frame_pulse <= take & in_beat.tlast;
      drop_pulse  <= take & ~keep_all;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/video_out_top.sv ====
// Video output top level
// Register block, raster timing and stream converter
`timescale 1ns/100ps
`default_nettype none

module video_out_top #(
  parameter int h_blank         = 280,
  parameter int hs_width        = 44,
  parameter int v_blank         = 45,
  parameter int line_addr_width = 10,
  parameter int sync_addr_width = 12
) (
  input  wire logic                     out_clk,
  input  wire logic                     rstn,
  input  wire logic                     reg_wr,
  input  wire logic [1:0]               reg_addr,
  input  wire logic [15:0]              reg_wdata,
  output logic [15:0]                   reg_rdata,
  input  wire stream_pkg::stream_beat_t in_beat,
  output logic                          tready,
  output video_pkg::sync_t              out_sync,
  output video_pkg::pixel_quad_t        out_pixels
);
  import video_pkg::*;

  dim_t  x_size;
  dim_t  y_size;
  sync_t raster;
  logic  stream_en;
  logic  frame_pulse;
  logic  drop_pulse;

  video_ctrl_regs u_video_ctrl_regs (
    .out_clk     (out_clk),
    .rstn        (rstn),
    .reg_wr      (reg_wr),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .frame_pulse (frame_pulse),
    .drop_pulse  (drop_pulse),
    .reg_rdata   (reg_rdata),
    .x_size      (x_size),
    .y_size      (y_size),
    .stream_en   (stream_en)
  );

  video_timing_gen #(
    .h_blank  (h_blank),
    .hs_width (hs_width),
    .v_blank  (v_blank)
  ) u_video_timing_gen (
    .out_clk (out_clk),
    .rstn    (rstn),
    .x_size  (x_size),
    .y_size  (y_size),
    .raster  (raster)
  );

  stream_to_video #(
    .line_addr_width (line_addr_width),
    .sync_addr_width (sync_addr_width)
  ) u_stream_to_video (
    .out_clk     (out_clk),
    .rstn        (rstn),
    .stream_en   (stream_en),
    .raster      (raster),
    .in_beat     (in_beat),
    .tready      (tready),
    .out_sync    (out_sync),
    .out_pixels  (out_pixels),
    .frame_pulse (frame_pulse),
    .drop_pulse  (drop_pulse)
  );

endmodule

`default_nettype wire

// ==== bench/tb_video_out.sv ====
// Directed testbench for the video output top level
// Clock, reset, register and wait helpers, compare tasks
// Beat driver with xorshift data, output model and timeout
`timescale 1ns/100ps
`default_nettype none

module tb_video_out;
  import video_pkg::*;
  import stream_pkg::*;

  localparam int   h_blank      = 8;
  localparam int   hs_width     = 3;
  localparam int   v_blank      = 3;
  localparam dim_t frame_x      = 11'd16;
  localparam dim_t frame_y      = 11'd4;
  localparam int   frame_cycles = (16 + h_blank) * (4 + v_blank);
  localparam int   num_tests    = 6;
  localparam int   cycle_limit  = num_tests * 8 * frame_cycles;

  logic         out_clk;
  logic         rstn;
  logic         reg_wr;
  logic [1:0]   reg_addr;
  logic [15:0]  reg_wdata;
  logic [15:0]  reg_rdata;
  stream_beat_t in_beat;
  logic         tready;
  sync_t        out_sync;
  pixel_quad_t  out_pixels;

  pixel_quad_t  model [$];        // Full quads accepted and not yet shown
  count_t       exp_frames = '0;
  count_t       exp_drops  = '0;
  logic [31:0]  rng        = 32'h988f;
  int           gen_idx    = 0;
  int           quads_seen = 0;
  int           cycle_cnt  = 0;
  int           error_cnt  = 0;
  int           check_cnt  = 0;
  int           tests_run  = 0;
  int           tests_failed = 0;
  logic         feed_on    = 1'b0;
  logic         make_drops = 1'b0; // Partial keep on some beats
  logic         last_all   = 1'b0; // tlast on every beat
  logic         beat_taken;

  video_out_top #(
    .h_blank         (h_blank),
    .hs_width        (hs_width),
    .v_blank         (v_blank),
    .line_addr_width (6),
    .sync_addr_width (6)
  ) u_video_out_top (
    .out_clk    (out_clk),
    .rstn       (rstn),
    .reg_wr     (reg_wr),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .in_beat    (in_beat),
    .tready     (tready),
    .out_sync   (out_sync),
    .out_pixels (out_pixels)
  );

  initial
  begin
    out_clk = 1'b0;
    forever #10 out_clk = ~out_clk;
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_quad(input string name, input pixel_quad_t got, input pixel_quad_t exp);
    check_cnt++;
    if (got !== exp)
    begin
      error_cnt++;
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input count_t got, input count_t exp);
    check_cnt++;
    if (got !== exp)
    begin
      error_cnt++;
      $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_dim(input string name, input dim_t got, input dim_t exp);
    check_cnt++;
    if (got !== exp)
    begin
      error_cnt++;
      $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp)
    begin
      error_cnt++;
      $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests_run++;
    if (error_cnt == errs_at_start)
      $display("[test] %s: ok", name);
    else
    begin
      tests_failed++;
      $display("[test] %s: %0d errors", name, error_cnt - errs_at_start);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus and wait helpers returning 2 ns after an edge
  ////////////////////////////////////////////////////////////

  task automatic reg_write(input logic [1:0] addr, input logic [15:0] data);
    reg_addr  = addr;
    reg_wdata = data;
    reg_wr    = 1'b1;
    @(posedge out_clk);
    #2;
    reg_wr = 1'b0;
  endtask

  task automatic reg_read(input logic [1:0] addr, output logic [15:0] data);
    reg_addr = addr;
    @(posedge out_clk);
    data = reg_rdata;            // Combinational read
    #2;
  endtask

  function automatic logic sync_bit(input string which);
    if (which == "vsync")
      return out_sync.vsync;
    return out_sync.de;
  endfunction

  task automatic wait_edge(input string which, input logic level);
    logic prev;
    logic cur;
    cur = sync_bit(which);
    do
    begin
      prev = cur;
      @(posedge out_clk);
      cur = sync_bit(which);
    end
    while (!(cur == level && prev != level));
    #2;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus source and output model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic stream_beat_t next_beat();
    stream_beat_t b;
    rng      = xorshift(rng);
    b.tvalid = 1'b1;
    b.tdata  = rng;
    b.tkeep  = (make_drops && (gen_idx % 21 == 5)) ? 4'b0111 : 4'hf;
    b.tdest  = 4'h0;
    b.tlast  = last_all || (gen_idx % 64 == 63);  // One frame is 64 beats
    gen_idx++;
    return b;
  endfunction

  // Hold each beat with tvalid high until it is taken
  always @(posedge out_clk)
  begin
    beat_taken = in_beat.tvalid && tready;
    #2;
    if (feed_on && (beat_taken || !in_beat.tvalid))
      in_beat = next_beat();
  end

  always @(posedge out_clk)
  begin
    if (out_sync.de)
    begin
      if (model.size() != 0)
      begin
        check_quad("out_pixels", out_pixels, model.pop_front());
        quads_seen++;
      end
      else
        check_quad("out_pixels", out_pixels, '0);   // Empty buffer
    end
    if (in_beat.tvalid && tready)
    begin
      if (in_beat.tkeep == 4'hf)
        model.push_back(in_beat.tdata);
      else
        exp_drops++;
      if (in_beat.tlast)
        exp_frames++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_test();
    int          errs;
    logic [15:0] rd;
    errs = error_cnt;
    repeat (5)
    begin
      @(posedge out_clk);
      check_bit("tready", tready, 1'b0);
      check_bit("out_sync", |out_sync, 1'b0);
      check_quad("out_pixels", out_pixels, '0);
    end
    #2;
    rstn = 1'b1;
    @(posedge out_clk);
    check_bit("tready", tready, 1'b0);
    check_bit("out_sync", |out_sync, 1'b0);
    check_quad("out_pixels", out_pixels, '0);
    #2;
    reg_read(2'd3, rd);
    check_count("frame count", rd[5:0], '0);
    check_count("drop count", rd[13:8], '0);
    report_test("reset", errs);
  endtask

  task automatic reg_test();
    int          errs;
    logic [15:0] rd;
    errs = error_cnt;
    reg_write(2'd0, 16'(frame_x));
    reg_write(2'd1, 16'(frame_y));
    reg_write(2'd2, 16'd1);
    reg_read(2'd0, rd);
    check_dim("x_size", rd[10:0], frame_x);
    reg_read(2'd1, rd);
    check_dim("y_size", rd[10:0], frame_y);
    reg_read(2'd2, rd);
    check_bit("stream_en", rd[0], 1'b1);
    reg_write(2'd2, 16'd0);
    reg_read(2'd2, rd);
    check_bit("stream_en", rd[0], 1'b0);
    report_test("registers", errs);
  endtask

  task automatic timing_test();
    int    errs;
    sync_t s;
    sync_t prev;
    dim_t  de_runs;
    dim_t  run_len;
    dim_t  hs_pulses;
    dim_t  hs_len;
    dim_t  frame_len;
    errs      = error_cnt;
    de_runs   = '0;
    run_len   = '0;
    hs_pulses = '0;
    hs_len    = '0;
    frame_len = '0;
    wait_edge("vsync", 1'b1);
    s = out_sync;
    do
    begin
      prev = s;
      @(posedge out_clk);
      s = out_sync;
      frame_len++;
      check_bit("out_sync.valid", s.valid, s.de);
      run_len = s.de ? run_len + 1'b1 : run_len;
      hs_len  = s.hsync ? hs_len + 1'b1 : hs_len;
      if (!s.de && prev.de)
      begin
        de_runs++;
        check_dim("out_sync.de run length", run_len, frame_x);
        run_len = '0;
      end
      if (!s.hsync && prev.hsync)
      begin
        hs_pulses++;
        check_dim("out_sync.hsync width", hs_len, dim_t'(hs_width));
        hs_len = '0;
      end
    end
    while (!(s.vsync && !prev.vsync));
    check_dim("out_sync.de runs", de_runs, frame_y);
    check_dim("out_sync.hsync pulses", hs_pulses, frame_y + dim_t'(v_blank));
    check_dim("frame length", frame_len, dim_t'(frame_cycles));
    #2;
    report_test("timing", errs);
  endtask

  task automatic stream_test();
    int errs;
    int seen0;
    errs = error_cnt;
    wait_edge("vsync", 1'b1);   // Enable well clear of the raster vsync
    feed_on = 1'b1;
    reg_write(2'd2, 16'd1);
    wait_edge("vsync", 1'b1);
    seen0 = quads_seen;
    wait_edge("vsync", 1'b1);
    wait_edge("vsync", 1'b1);
    check_dim("quads in two frames", dim_t'(quads_seen - seen0), 2 * frame_x * frame_y);
    report_test("stream", errs);
  endtask

  task automatic drop_test();
    int          errs;
    logic [15:0] rd;
    errs       = error_cnt;
    make_drops = 1'b1;
    last_all   = 1'b1;      // Enough tlast beats to wrap the frame count
    wait_edge("vsync", 1'b1);
    wait_edge("vsync", 1'b1);
    make_drops = 1'b0;
    last_all   = 1'b0;
    wait_edge("vsync", 1'b1);
    reg_read(2'd3, rd);
    check_count("frame count", rd[5:0], exp_frames);
    check_count("drop count", rd[13:8], exp_drops);
    check_bit("status pad bits", |{rd[15:14], rd[7:6]}, 1'b0);  // Counters wrap in 6 bits
    report_test("drops", errs);
  endtask

  task automatic disable_test();
    int errs;
    int seen0;
    errs = error_cnt;
    wait_edge("vsync", 1'b1);
    seen0 = quads_seen;
    wait_edge("de", 1'b1);      // Mid frame
    reg_write(2'd2, 16'd0);
    wait_edge("vsync", 1'b1);
    wait_edge("vsync", 1'b0);
    check_dim("quads in last frame", dim_t'(quads_seen - seen0), frame_x * frame_y);
    check_dim("quads left in model", dim_t'(model.size()), '0);
    repeat (frame_cycles)
    begin
      @(posedge out_clk);
      check_bit("tready", tready, 1'b0);
      check_quad("out_pixels", out_pixels, '0);
    end
    #2;
    report_test("disable", errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence and timeout
  ////////////////////////////////////////////////////////////

  always @(posedge out_clk)
    cycle_cnt <= cycle_cnt + 1;

  initial
  begin
    wait (cycle_cnt >= cycle_limit);
    $display("Timeout: run stopped after %0d cycles without finishing", cycle_limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    rstn      = 1'b0;
    reg_wr    = 1'b0;
    reg_addr  = 2'd0;
    reg_wdata = 16'd0;
    in_beat   = '0;
    reset_test();
    reg_test();
    timing_test();
    stream_test();
    drop_test();
    disable_test();
    $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             tests_run, tests_failed, check_cnt, error_cnt);
    if (error_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/video_pkg.sv
hdl/stream_pkg.sv
hdl/video_ctrl_regs.sv
hdl/video_timing_gen.sv
hdl/line_fifo.sv
hdl/stream_to_video.sv
hdl/video_out_top.sv
bench/tb_video_out.sv

// ==== Bender.yml ====
package:
  name: video_out

sources:
  - files:
      - hdl/video_pkg.sv
      - hdl/stream_pkg.sv
      - hdl/video_ctrl_regs.sv
      - hdl/video_timing_gen.sv
      - hdl/line_fifo.sv
      - hdl/stream_to_video.sv
      - hdl/video_out_top.sv
  - target: simulation
    files:
      - bench/tb_video_out.sv
